// ==== rtl/ifetch_pkg.sv ====
package ifetch_pkg;

    localparam int xlen = 32;  // Address and instruction width

    typedef logic [xlen-1:0] pc_t;
    typedef logic [xlen-1:0] instr_t;

    // Buffer payload, 80 bits wide
    typedef struct packed {
        logic [14:0] spare;  // Pads the entry to 80 bits
        logic        fault;  // Bus error on this fetch
        instr_t      instr;
        pc_t         pc;
    } fetch_entry_t;

    typedef enum logic [1:0] {
        kind_other  = 2'd0,
        kind_jal    = 2'd1,
        kind_jalr   = 2'd2,
        kind_branch = 2'd3
    } instr_kind_t;

    // Predecoded instruction toward the core
    typedef struct packed {
        pc_t         pc;
        instr_t      instr;
        logic        fault;
        instr_kind_t kind;
        pc_t         target;  // Zero unless jal or branch
    } fetch_out_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [2:0]      prot;
    } axil_ar_t;

    typedef struct packed {
        logic [xlen-1:0] data;
        logic [1:0]      resp;
    } axil_r_t;

    typedef struct packed {
        logic valid;
        pc_t  pc;
    } redirect_t;

    localparam logic [1:0] resp_okay = 2'b00;

endpackage

// ==== rtl/fetch_requester.sv ====
module fetch_requester import ifetch_pkg::*; #(
    parameter int  depth           = 16,
    parameter int  max_outstanding = 4,
    parameter pc_t reset_pc        = 32'h0000_1000
) (
    input  logic                       clock,
    input  logic                       reset_n,
    input  redirect_t                  redirect,
    input  logic                       ar_ready,
    input  logic                       r_valid,
    input  axil_r_t                    r,
    input  logic [$clog2(depth+1)-1:0] buf_count,
    output logic                       ar_valid,
    output axil_ar_t                   ar,
    output logic                       r_ready,
    output logic                       wr_en,
    output fetch_entry_t               wr_data
);

    localparam int ow = $clog2(max_outstanding + 1);                  // Reads in flight width
    localparam int pw = (max_outstanding > 1) ? $clog2(max_outstanding) : 1;  // Tag pointer
    localparam logic [2:0] prot_instr = 3'b100;  // Unprivileged, secure, instruction

    pc_t           next_pc;     // Address of the next request to raise
    pc_t           ar_addr;
    logic [ow-1:0] issued;      // Raised on AR but not yet answered on R
    logic [ow-1:0] stale;       // Responses still owed to an old stream
    pc_t           pc_mem [max_outstanding];
    logic [pw-1:0] tag_wr_ptr;
    logic [pw-1:0] tag_rd_ptr;
    logic          ar_hs;
    logic          r_hs;
    logic          credit_ok;
    logic          issue;

    function automatic logic [pw-1:0] bump(input logic [pw-1:0] p);
        return (p == pw'(max_outstanding - 1)) ? '0 : p + 1'b1;
    endfunction

    assign ar_hs = ar_valid && ar_ready;
    assign r_hs  = r_valid && r_ready;

    // Every read owns a buffer slot before it goes out
    assign credit_ok = (int'(issued) < max_outstanding) &&
                       ((int'(issued) + int'(buf_count)) < depth);

    // New address only when the AR slot is free or freeing
    assign issue = (!ar_valid || ar_hs) && !redirect.valid && credit_ok;

    assign ar = '{addr: ar_addr, prot: prot_instr};

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            next_pc    <= reset_pc;
            ar_valid   <= 1'b0;
            issued     <= '0;
            stale      <= '0;
            tag_wr_ptr <= '0;
            tag_rd_ptr <= '0;
            r_ready    <= 1'b0;
        end else begin
            r_ready <= 1'b1;  // Never back-pressures R
            issued  <= issued + ow'(issue) - ow'(r_hs);

            if (issue) begin
                ar_valid   <= 1'b1;
                tag_wr_ptr <= bump(tag_wr_ptr);
            end else if (ar_hs) begin
                ar_valid <= 1'b0;
            end

            if (r_hs) begin
                tag_rd_ptr <= bump(tag_rd_ptr);  // Stale responses pop their tag too
            end

            if (redirect.valid) begin
                next_pc <= redirect.pc;
                // Whatever is still owed, pending AR included, belongs to the old stream
                stale <= issued - ow'(r_hs);
            end else begin
                if (issue) begin
                    next_pc <= next_pc + 32'd4;
                end
                if (r_hs && (stale != '0)) begin
                    stale <= stale - 1'b1;
                end
            end
        end
    end

    // Address and PC tag capture
    always_ff @(posedge clock) begin
        if (issue) begin
            ar_addr            <= next_pc;
            pc_mem[tag_wr_ptr] <= next_pc;
        end
    end

    assign wr_en = r_hs && (stale == '0);  // Dropped while old stream drains

    always_comb begin
        wr_data       = '0;
        wr_data.pc    = pc_mem[tag_rd_ptr];  // Responses return in AR order
        wr_data.instr = r.data;
        wr_data.fault = (r.resp != resp_okay);
    end

endmodule

// ==== rtl/instr_buffer.sv ====
module instr_buffer import ifetch_pkg::*; #(
    parameter int depth = 16
) (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       clear,
    input  logic                       wr_en,
    input  fetch_entry_t               wr_data,
    input  logic                       take,
    input  logic                       stall,
    output fetch_entry_t               rd_data,
    output logic                       data_valid,
    output logic [$clog2(depth+1)-1:0] count,
    output logic                       empty,
    output logic                       full
);

    localparam int aw = $clog2(depth);      // Pointer width
    localparam int cw = $clog2(depth + 1);  // Count reaches depth

    fetch_entry_t  mem [depth];
    logic [aw-1:0] rd_ptr;
    logic [aw-1:0] wr_ptr;
    logic          do_write;
    logic          do_read;

    // Wrap at depth, not at a power of two
    function automatic logic [aw-1:0] bump(input logic [aw-1:0] p);
        return (p == aw'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == cw'(depth));

    assign do_write = wr_en && !full;
    assign do_read  = take && !stall && !empty;  // Stall freezes the output stage

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Output register, held through stall
    always_ff @(posedge clock) begin
        if (do_read && !clear) begin
            rd_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            count      <= '0;
            data_valid <= 1'b0;
        end else if (clear) begin
            // Redirect flush wins over take and stall
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            count      <= '0;
            data_valid <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= bump(rd_ptr);
            end

            if (!stall) begin
                data_valid <= do_read;  // Take on empty drops valid
            end

            // Simultaneous write and read cancel out
            count <= count + cw'(do_write) - cw'(do_read);
        end
    end

endmodule

// ==== rtl/predecode.sv ====
module predecode import ifetch_pkg::*; (
    input  fetch_entry_t entry,
    input  logic         entry_valid,
    output fetch_out_t   out,
    output logic         out_valid
);

    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;

    logic [6:0]  opcode;
    instr_t      imm_j;
    instr_t      imm_b;
    instr_kind_t kind;
    pc_t         target;

    assign opcode = entry.instr[6:0];

    // J-type immediate, bit 0 always zero
    assign imm_j = {{12{entry.instr[31]}}, entry.instr[19:12], entry.instr[20],
                    entry.instr[30:21], 1'b0};

    // B-type immediate
    assign imm_b = {{20{entry.instr[31]}}, entry.instr[7], entry.instr[30:25],
                    entry.instr[11:8], 1'b0};

    always_comb begin
        case (opcode)
            op_jal:    kind = kind_jal;
            op_jalr:   kind = kind_jalr;
            op_branch: kind = kind_branch;
            default:   kind = kind_other;
        endcase
        if (entry.fault) begin
            kind = kind_other;  // Word is garbage on a bus error
        end
    end

    always_comb begin
        case (kind)
            kind_jal:    target = entry.pc + imm_j;
            kind_branch: target = entry.pc + imm_b;
            default:     target = '0;  // jalr needs a register, left to the core
        endcase
    end

    assign out = '{
        pc:     entry.pc,
        instr:  entry.instr,
        fault:  entry.fault,
        kind:   kind,
        target: target
    };

    assign out_valid = entry_valid;  // Same cycle as the buffer flag

endmodule

// ==== rtl/ifetch_top.sv ====
module ifetch_top import ifetch_pkg::*; #(
    parameter int  depth           = 16,
    parameter int  max_outstanding = 4,
    parameter pc_t reset_pc        = 32'h0000_1000
) (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       ar_ready,
    input  logic                       r_valid,
    input  axil_r_t                    r,
    input  logic                       take,
    input  logic                       stall,
    input  redirect_t                  redirect,
    output logic                       ar_valid,
    output axil_ar_t                   ar,
    output logic                       r_ready,
    output logic                       out_valid,
    output fetch_out_t                 out,
    output logic [$clog2(depth+1)-1:0] count
);

    logic         wr_en;
    fetch_entry_t wr_data;
    fetch_entry_t rd_data;
    logic         data_valid;

    // AXI4-Lite read master and PC walk
    fetch_requester #(
        .depth           (depth),
        .max_outstanding (max_outstanding),
        .reset_pc        (reset_pc)
    ) u_requester (
        .clock     (clock),
        .reset_n   (reset_n),
        .redirect  (redirect),
        .ar_ready  (ar_ready),
        .r_valid   (r_valid),
        .r         (r),
        .buf_count (count),  // Credit check against buffer fill
        .ar_valid  (ar_valid),
        .ar        (ar),
        .r_ready   (r_ready),
        .wr_en     (wr_en),
        .wr_data   (wr_data)
    );

    instr_buffer #(
        .depth (depth)
    ) u_buffer (
        .clock      (clock),
        .reset_n    (reset_n),
        .clear      (redirect.valid),  // Flush on redirect
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .take       (take),
        .stall      (stall),
        .rd_data    (rd_data),
        .data_valid (data_valid),
        .count      (count),
        .empty      (),
        .full       ()
    );

    predecode u_predecode (
        .entry       (rd_data),
        .entry_valid (data_valid),
        .out         (out),
        .out_valid   (out_valid)
    );

endmodule

// ==== tests/axil_instr_mem.sv ====
module axil_instr_mem import ifetch_pkg::*; #(
    parameter logic [31:0] seed = 32'd72718
) (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     ar_valid,
    input  axil_ar_t ar,
    output logic     ar_ready,
    output logic     r_valid,
    output axil_r_t  r,
    input  logic     r_ready
);

    logic [31:0] lfsr;
    logic [31:0] pending [$];  // Accepted addresses, answered in order
    int          delay;        // Idle cycles left before the head answers

    // Opcode from the word index, everything else from a hash of the address
    function automatic logic [31:0] word_at(input logic [31:0] a);
        logic [31:0] h;
        logic [20:0] ij;
        logic [12:0] ib;
        h  = (a ^ 32'h5a5a_0f0f) * 32'h9e37_79b1;
        h  = h ^ (h >> 15);
        ij = {h[20:1], 1'b0};  // J-type offset
        ib = {h[12:1], 1'b0};  // B-type offset
        case (a[3:2])
            2'd0: return {ij[20], ij[10:1], ij[11], ij[19:12], h[11:7], 7'b1101111};
            2'd1: return {h[31:15], 3'b000, h[11:7], 7'b1100111};
            2'd2: return {ib[12], ib[10:5], h[24:15], h[14:12], ib[4:1], ib[11], 7'b1100011};
            default: return {h[31:7], 7'b0010011};  // addi
        endcase
    endfunction

    // Galois LFSR, one step per bit drawn
    task automatic draw(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
    endtask

    initial begin
        lfsr     = seed;
        delay    = 0;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r        = '0;
    end

    always @(posedge clock or negedge reset_n) begin
        int pick;
        if (!reset_n) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            pending.delete();
            delay = 0;
        end else begin
            if (r_valid && r_ready) begin
                pending.delete(0);
                draw(3, pick);
                delay = pick % 6;  // 0 to 5 cycles before the next answer
            end
            if (ar_valid && ar_ready) begin
                pending.push_back(ar.addr);
            end
            draw(2, pick);
            ar_ready <= (pick != 0);  // Ready three cycles in four
            if (!r_valid || r_ready) begin
                if (pending.size() != 0 && delay == 0) begin
                    r_valid <= 1'b1;
                    if (pending[0] >= 32'h2000 && pending[0] <= 32'h20ff) begin
                        r <= '{data: '0, resp: 2'b10};  // SLVERR window
                    end else begin
                        r <= '{data: word_at(pending[0]), resp: resp_okay};
                    end
                end else begin
                    r_valid <= 1'b0;
                    if (delay > 0) delay--;
                end
            end
        end
    end

endmodule

// ==== tests/tb_ifetch.sv ====
module tb_ifetch import ifetch_pkg::*; ();

    localparam int  depth           = 16;
    localparam int  max_outstanding = 4;
    localparam pc_t reset_pc        = 32'h0000_1000;
    localparam int  cw              = $clog2(depth + 1);

    logic          clock = 1'b0;
    logic          reset_n;
    logic          take;
    logic          stall;
    redirect_t     redirect;
    logic          ar_valid;
    logic          ar_ready;
    axil_ar_t      ar;
    logic          r_valid;
    logic          r_ready;
    axil_r_t       r;
    logic          out_valid;
    fetch_out_t    out;
    logic [cw-1:0] count;

    logic [31:0] lfsr           = 32'd72718;
    pc_t         exp_pc         = reset_pc;  // Next PC due on out
    pc_t         exp_addr       = reset_pc;  // Next address due on AR
    int          inflight       = 0;         // AR accepted minus R answered
    int          seen           = 0;         // Outputs checked so far
    int          busy_redirects = 0;         // Redirects with reads outstanding
    logic        skip_ar        = 1'b0;      // Old-stream address still pending
    logic        held           = 1'b0;      // Stall at the previous edge
    logic        flushed        = 1'b0;      // Redirect at the previous edge
    logic        last_valid     = 1'b0;
    fetch_out_t  last_out;

    ifetch_top #(
        .depth           (depth),
        .max_outstanding (max_outstanding),
        .reset_pc        (reset_pc)
    ) DUT (
        .clock(clock), .reset_n(reset_n), .ar_ready(ar_ready), .r_valid(r_valid), .r(r),
        .take(take), .stall(stall), .redirect(redirect), .ar_valid(ar_valid), .ar(ar),
        .r_ready(r_ready), .out_valid(out_valid), .out(out), .count(count)
    );

    axil_instr_mem u_mem (
        .clock(clock), .reset_n(reset_n), .ar_valid(ar_valid), .ar(ar), .ar_ready(ar_ready),
        .r_valid(r_valid), .r(r), .r_ready(r_ready)
    );

    always #20 clock = ~clock;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic draw(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
    endtask

    // Expected output for a PC, built from the memory encoding rules
    function automatic fetch_out_t expected_out(input pc_t pc);
        fetch_out_t  e;
        logic [31:0] h;
        logic [20:0] ij;
        logic [12:0] ib;
        h  = (pc ^ 32'h5a5a_0f0f) * 32'h9e37_79b1;
        h  = h ^ (h >> 15);
        ij = {h[20:1], 1'b0};
        ib = {h[12:1], 1'b0};
        e  = '0;  // kind_other, target zero
        e.pc = pc;
        if (pc >= 32'h2000 && pc <= 32'h20ff) begin
            e.fault = 1'b1;  // Bus error, data zero
            return e;
        end
        case (pc[3:2])
            2'd0: begin
                e.instr  = {ij[20], ij[10:1], ij[11], ij[19:12], h[11:7], 7'b1101111};
                e.kind   = kind_jal;
                e.target = pc + {{11{ij[20]}}, ij};
            end
            2'd1: begin
                e.instr = {h[31:15], 3'b000, h[11:7], 7'b1100111};
                e.kind  = kind_jalr;
            end
            2'd2: begin
                e.instr  = {ib[12], ib[10:5], h[24:15], h[14:12], ib[4:1], ib[11], 7'b1100011};
                e.kind   = kind_branch;
                e.target = pc + {{19{ib[12]}}, ib};
            end
            default: e.instr = {h[31:7], 7'b0010011};
        endcase
        return e;
    endfunction

    function automatic string describe(input fetch_out_t o);
        return $sformatf("pc %h instr %h fault %b kind %0d target %h",
                         o.pc, o.instr, o.fault, o.kind, o.target);
    endfunction

    // AXI side: address order and credit limits
    always @(posedge clock) begin
        if (reset_n) begin
            assert (inflight <= max_outstanding) else stop_with_error($sformatf(
                "Mismatch at %0t: %0d reads in flight", $time, inflight));
            assert (int'(count) + inflight <= depth) else stop_with_error($sformatf(
                "Mismatch at %0t: count %0d plus %0d in flight", $time, count, inflight));
            if (ar_valid && ar_ready) begin
                // Instruction access, unprivileged, secure
                assert (ar.prot == 3'b100) else stop_with_error($sformatf(
                    "Mismatch at %0t: AR prot %b, expected 100", $time, ar.prot));
                if (skip_ar) begin
                    skip_ar = 1'b0;  // Stale address, accepted late
                end else begin
                    assert (ar.addr == exp_addr) else stop_with_error($sformatf(
                        "Mismatch at %0t: AR addr %h, expected %h", $time, ar.addr, exp_addr));
                    exp_addr = exp_addr + 4;
                end
            end
            if (redirect.valid && (inflight > 0 || ar_valid)) busy_redirects++;
            inflight = inflight + int'(ar_valid && ar_ready) - int'(r_valid && r_ready);
            if (redirect.valid) begin
                exp_addr = redirect.pc;
                skip_ar  = ar_valid && !ar_ready;
            end
        end
    end

    // Output side: compare against the reference
    always @(posedge clock) begin
        fetch_out_t want;
        if (reset_n) begin
            if (flushed) begin
                assert (!out_valid) else stop_with_error($sformatf(
                    "Mismatch at %0t: out_valid high right after redirect", $time));
            end else if (held) begin
                assert (out_valid == last_valid && (!last_valid || out == last_out))
                    else stop_with_error($sformatf(
                        "Mismatch at %0t: output moved during stall", $time));
            end else if (out_valid) begin
                want = expected_out(exp_pc);
                assert (out == want) else stop_with_error($sformatf(
                    "Mismatch at %0t: got %s, expected %s", $time, describe(out),
                    describe(want)));
                exp_pc = exp_pc + 4;
                seen++;
            end
            last_valid = out_valid;
            last_out   = out;
            held       = stall && !redirect.valid;  // Redirect overrides stall
            flushed    = redirect.valid;
            if (redirect.valid) exp_pc = redirect.pc;
        end
    end

    task automatic wait_for_outputs(input int n, input int limit, input string what);
        int target;
        int cycles;
        target = seen + n;
        cycles = 0;
        while (seen < target) begin
            @(negedge clock);
            cycles++;
            if (cycles > limit) stop_with_error($sformatf("Timeout: no %0d outputs %s", n, what));
        end
    endtask

    task automatic wait_for_fill(input int limit);
        int cycles;
        cycles = 0;
        while (count != cw'(depth)) begin
            @(negedge clock);
            cycles++;
            if (cycles > limit) stop_with_error("Timeout: buffer never filled with take low");
        end
    endtask

    task automatic send_redirect(input pc_t pc);
        @(posedge clock);
        redirect <= '{valid: 1'b1, pc: pc};
        @(posedge clock);
        redirect <= '0;
    endtask

    initial begin
        int v;
        reset_n  = 1'b0;
        take     = 1'b0;
        stall    = 1'b0;
        redirect = '0;
        repeat (5) @(posedge clock);
        assert (!ar_valid && !out_valid && count == '0)
            else stop_with_error("Outputs were not idle during reset");
        reset_n <= 1'b1;
        @(posedge clock);
        @(negedge clock);
        assert (ar_valid && r_ready) else stop_with_error("Fetch did not start after reset");

        @(posedge clock);
        take <= 1'b1;  // Straight stream, all four kinds
        wait_for_outputs(40, 600, "with take held high");

        repeat (300) begin  // Random take and stall
            @(posedge clock);
            draw(1, v);
            take <= v[0];
            draw(2, v);
            stall <= (v == 0);
        end

        @(posedge clock);
        take  <= 1'b0;
        stall <= 1'b0;
        wait_for_fill(400);
        repeat (8) @(posedge clock);
        @(negedge clock);
        assert (count == cw'(depth) && !ar_valid && inflight == 0)
            else stop_with_error("Fetch kept going with the buffer full");
        @(posedge clock);
        take <= 1'b1;
        wait_for_outputs(depth + 8, 600, "while draining a full buffer");

        repeat (6) @(posedge clock);
        send_redirect(32'h0000_3000);
        wait_for_outputs(16, 400, "after redirect to 0x3000");
        send_redirect(32'h0000_2000);  // Fault window
        wait_for_outputs(12, 400, "inside the fault window");
        send_redirect(32'h0000_1800);
        wait_for_outputs(12, 400, "after leaving the fault window");

        if (busy_redirects > 0) begin
            $display("Test OK");
            $finish;
        end else begin
            stop_with_error("No redirect hit reads in flight");
        end
    end

endmodule

// ==== ifetch.f ====
rtl/ifetch_pkg.sv
rtl/fetch_requester.sv
rtl/instr_buffer.sv
rtl/predecode.sv
rtl/ifetch_top.sv
tests/axil_instr_mem.sv
tests/tb_ifetch.sv

// ==== Makefile ====
# Verilator build and run of the instruction fetch testbench

VERILATOR ?= verilator
TOP       ?= tb_ifetch
FILELIST  ?= ifetch.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Test OK" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
